// ==== backend.f ====
verilog/backend_pkg.sv
verilog/id.sv
verilog/regfile.sv
verilog/dispatch.sv
verilog/ex.sv
verilog/mem.sv
verilog/ctrl.sv
verilog/backend.sv
bench/backend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= backend_tb
FLIST     ?= backend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/backend_input.txt ====
# I addr word : program image, E pc rd value : expected commit (rd 00 means no write)
# D addr value : expected final data memory word, all fields hex
I 00000000 02801401
I 00000004 02bff402
I 00000008 00100823
I 0000000c 00110444
I 00000010 00120445
I 00000014 00128446
I 00000018 00148887
I 0000001c 00151068
I 00000020 00158509
I 00000024 02801d20
I 00000028 0010040a
I 0000002c 0284000b
I 00000030 29800169
I 00000034 29801164
I 00000038 2880016c
I 0000003c 0280058d
I 00000040 2880116e
I 00000044 001035cf
I 00000048 58000da0
I 0000004c 02800410
I 00000050 02800810
I 00000054 5c000c2a
I 00000058 02804411
I 0000005c 5c000a20
I 00000060 02808812
I 00000064 29802171
I 00000068 28802173
I 0000006c 00103e74
E 00000000 01 00000005
E 00000004 02 fffffffd
E 00000008 03 00000002
E 0000000c 04 fffffff8
E 00000010 05 00000001
E 00000014 06 00000000
E 00000018 07 fffffff8
E 0000001c 08 fffffffa
E 00000020 09 ffffffff
E 00000024 00 00000000
E 00000028 0a 00000005
E 0000002c 0b 00000100
E 00000030 00 00000000
E 00000034 00 00000000
E 00000038 0c ffffffff
E 0000003c 0d 00000000
E 00000040 0e fffffff8
E 00000044 0f fffffff8
E 00000048 00 00000000
E 00000054 00 00000000
E 00000058 11 00000011
E 0000005c 00 00000000
E 00000064 00 00000000
E 00000068 13 00000011
E 0000006c 14 00000009
D 00000100 ffffffff
D 00000104 fffffff8
D 00000108 00000011
D 0000010c ffbc0043

// ==== bench/backend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module backend_tb;
    import backend_pkg::*;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 1024;
    localparam int MAX_ITEMS  = 64;

    logic      clk;
    logic      rst_n_i;
    fe_inst_t  fe_i;
    logic      inst_accept_o;
    redirect_t redirect_o;
    dmem_req_t dmem_req_o;
    word_t     dmem_rdata_i;
    commit_t   commit_o;

    word_t     imem [IMEM_WORDS];
    word_t     dmem [DMEM_WORDS];
    word_t     exp_pc [MAX_ITEMS];
    reg_addr_t exp_rd [MAX_ITEMS];
    word_t     exp_val [MAX_ITEMS];
    word_t     chk_addr [MAX_ITEMS];
    word_t     chk_val [MAX_ITEMS];
    int        prog_len;
    int        n_exp;
    int        n_chk;
    int        n_commit;
    int        checks;
    int        errors;
    word_t     pc;

    backend UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fe_i          (fe_i),
        .inst_accept_o (inst_accept_o),
        .redirect_o    (redirect_o),
        .dmem_req_o    (dmem_req_o),
        .dmem_rdata_i  (dmem_rdata_i),
        .commit_o      (commit_o)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("FAIL at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic read_input();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        word_t            a;
        word_t            v;
        reg_addr_t        r;
        fd = $fopen("bench/backend_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/backend_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                break;
            if (tag == "I") begin
                code = $fscanf(fd, "%h %h", a, v);
                imem[a[9:2]] = v;
                if (int'(a >> 2) >= prog_len)
                    prog_len = int'(a >> 2) + 1;
            end else if (tag == "E" && n_exp < MAX_ITEMS) begin
                code = $fscanf(fd, "%h %h %h", a, r, v);
                exp_pc[n_exp]  = a;
                exp_rd[n_exp]  = r;
                exp_val[n_exp] = v;
                n_exp++;
            end else if (tag == "D" && n_chk < MAX_ITEMS) begin
                code = $fscanf(fd, "%h %h", a, v);
                chk_addr[n_chk] = a;
                chk_val[n_chk]  = v;
                n_chk++;
            end else begin
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    // past the end of the image the front end goes idle
    task automatic drive_fetch();
        fe_i.pc    = pc;
        fe_i.valid = (pc < word_t'(prog_len * 4));
        fe_i.inst  = imem[pc[9:2]];
    endtask

    task automatic serve_dmem(input dmem_req_t req);
        if (req.valid) begin
            if (req.addr >= word_t'(DMEM_WORDS * 4) || req.addr[1:0] != 2'b00) begin
                $display("data memory request to a bad address %h", req.addr);
                errors++;
            end else if (req.write) begin
                dmem[req.addr[11:2]] = req.wdata;
            end else begin
                dmem_rdata_i = dmem[req.addr[11:2]];
            end
        end
    endtask

    task automatic check_commit(input commit_t c);
        if (n_commit >= n_exp) begin
            $display("unexpected commit of pc %h after the end of the trace", c.pc);
            errors++;
        end else begin
            checks++;
            if (c.pc !== exp_pc[n_commit])
                report_mismatch("commit_o.pc", exp_pc[n_commit], c.pc);
            if (exp_rd[n_commit] == '0) begin
                if (c.reg_write_en !== 1'b0)
                    report_mismatch("commit_o.reg_write_en", 32'd0, {31'b0, c.reg_write_en});
            end else begin
                if (c.reg_write_en !== 1'b1)
                    report_mismatch("commit_o.reg_write_en", 32'd1, {31'b0, c.reg_write_en});
                if (c.rd !== exp_rd[n_commit])
                    report_mismatch("commit_o.rd", {27'b0, exp_rd[n_commit]}, {27'b0, c.rd});
                if (c.data !== exp_val[n_commit])
                    report_mismatch("commit_o.data", exp_val[n_commit], c.data);
            end
        end
        n_commit++;
    endtask

    task automatic check_dmem();
        for (int k = 0; k < n_chk; k++) begin
            if (dmem[chk_addr[k][11:2]] !== chk_val[k])
                report_mismatch($sformatf("dmem[%h]", chk_addr[k]), chk_val[k],
                                dmem[chk_addr[k][11:2]]);
        end
    endtask

    initial begin
        int        cycles;
        int        limit;
        int        drain;
        int        trace_errors;
        logic      took;
        redirect_t redir;
        dmem_req_t req;
        commit_t   cmt;

        clk          = 1'b0;
        rst_n_i      = 1'b0;
        fe_i         = '0;
        dmem_rdata_i = '0;
        pc           = '0;
        prog_len     = 0;
        n_exp        = 0;
        n_chk        = 0;
        n_commit     = 0;
        checks       = 0;
        errors       = 0;
        cycles       = 0;
        drain        = 0;
        // pattern differs for every word index
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = {i[15:0], ~i[15:0]};
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = {~i[15:0], i[15:0]};
        read_input();
        limit = prog_len * 8 + 100;

        repeat (4) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        drive_fetch();

        // sample mid-cycle, act just after the next rising edge
        while (drain < 8 && cycles < limit) begin
            @(negedge clk);
            took  = fe_i.valid && inst_accept_o;
            redir = redirect_o;
            req   = dmem_req_o;
            cmt   = commit_o;
            @(posedge clk);
            #5;
            cycles++;
            if (redir.valid)
                pc = redir.target;
            else if (took)
                pc = pc + 32'd4;
            drive_fetch();
            serve_dmem(req);
            if (cmt.valid)
                check_commit(cmt);
            if (n_commit >= n_exp)
                drain++;
        end

        if (drain < 8) begin
            $display("timeout after %0d cycles with %0d of %0d commits seen",
                     cycles, n_commit, n_exp);
            errors++;
        end
        trace_errors = errors;
        $display("test commit_trace: %0d commits checked, %0d errors", checks, trace_errors);
        check_dmem();
        $display("test final_memory: %0d words checked, %0d errors", n_chk, errors - trace_errors);
        $display("summary: 2 tests, %0d checks, %0d errors", checks + n_chk, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module backend (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire backend_pkg::fe_inst_t fe_i,
    output logic                       inst_accept_o,
    output backend_pkg::redirect_t     redirect_o,
    output backend_pkg::dmem_req_t     dmem_req_o,
    input  wire backend_pkg::word_t    dmem_rdata_i,
    output backend_pkg::commit_t       commit_o
);
    import backend_pkg::*;

    pipe_ctrl_t pipe_ctrl;
    id_disp_t   id_q;
    disp_ex_t   disp_q;
    ex_mem_t    ex_q;
    fwd_t       ex_fwd;
    fwd_t       mem_fwd;
    fwd_t       wb_wr;
    reg_addr_t  raddr_a;
    reg_addr_t  raddr_b;
    word_t      rdata_a;
    word_t      rdata_b;
    word_t      branch_target;
    logic       ex_is_load;
    logic       stall_req;
    logic       branch_taken;

    // retiring write goes back to the register file
    assign wb_wr.write_en = commit_o.valid && commit_o.reg_write_en;
    assign wb_wr.addr     = commit_o.rd;
    assign wb_wr.data     = commit_o.data;

    id u_id (
        .clk,
        .rst_n_i,
        .fe_i,
        .pipe_ctrl_i (pipe_ctrl),
        .id_o        (id_q)
    );

    regfile u_regfile (
        .clk,
        .rst_n_i,
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wr_i      (wb_wr)
    );

    dispatch u_dispatch (
        .clk,
        .rst_n_i,
        .id_i         (id_q),
        .pipe_ctrl_i  (pipe_ctrl),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .ex_is_load_i (ex_is_load),
        .raddr_a_o    (raddr_a),
        .raddr_b_o    (raddr_b),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .stall_req_o  (stall_req),
        .disp_o       (disp_q)
    );

    ex u_ex (
        .clk,
        .rst_n_i,
        .disp_i          (disp_q),
        .ex_fwd_o        (ex_fwd),
        .ex_is_load_o    (ex_is_load),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_o            (ex_q)
    );

    mem u_mem (
        .clk,
        .rst_n_i,
        .ex_i         (ex_q),
        .dmem_req_o,
        .dmem_rdata_i,
        .mem_fwd_o    (mem_fwd),
        .commit_o
    );

    ctrl u_ctrl (
        .clk,
        .rst_n_i,
        .stall_req_i     (stall_req),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pipe_ctrl_o     (pipe_ctrl),
        .inst_accept_o,
        .redirect_o
    );

endmodule

`default_nettype wire

// ==== verilog/ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               stall_req_i,
    input  wire logic               branch_taken_i,
    input  wire backend_pkg::word_t branch_target_i,
    output backend_pkg::pipe_ctrl_t pipe_ctrl_o,
    output logic                    inst_accept_o,
    output backend_pkg::redirect_t  redirect_o
);
    import backend_pkg::*;

    redirect_t redirect_q;

    // flush wins over stall
    assign pipe_ctrl_o.id_flush   = branch_taken_i || redirect_q.valid;
    assign pipe_ctrl_o.disp_flush = branch_taken_i;
    assign pipe_ctrl_o.id_stall   = stall_req_i && !branch_taken_i && !redirect_q.valid;
    assign pipe_ctrl_o.disp_stall = stall_req_i && !branch_taken_i;

    assign inst_accept_o = !pipe_ctrl_o.id_stall;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_q <= '0;
        end else begin
            redirect_q.valid  <= branch_taken_i;
            redirect_q.target <= branch_target_i;
        end
    end

    assign redirect_o = redirect_q;

endmodule

`default_nettype wire

// ==== verilog/mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire backend_pkg::ex_mem_t ex_i,
    output backend_pkg::dmem_req_t    dmem_req_o,
    input  wire backend_pkg::word_t   dmem_rdata_i,
    output backend_pkg::fwd_t         mem_fwd_o,
    output backend_pkg::commit_t      commit_o
);
    import backend_pkg::*;

    ex_mem_t hold_q;
    word_t   wb_data;

    assign dmem_req_o.valid = ex_i.valid && (ex_i.is_load || ex_i.is_store);
    assign dmem_req_o.write = ex_i.is_store;
    assign dmem_req_o.addr  = ex_i.result;
    assign dmem_req_o.wdata = ex_i.store_data;

    // record waits here while the read is in flight
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            hold_q <= '0;
        else
            hold_q <= ex_i;
    end

    assign wb_data = hold_q.is_load ? dmem_rdata_i : hold_q.result;

    assign mem_fwd_o.write_en = hold_q.valid && hold_q.reg_write_en;
    assign mem_fwd_o.addr     = hold_q.rd;
    assign mem_fwd_o.data     = wb_data;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= '0;
        end else begin
            commit_o.valid        <= hold_q.valid;
            commit_o.pc           <= hold_q.pc;
            commit_o.reg_write_en <= hold_q.valid && hold_q.reg_write_en;
            commit_o.rd           <= hold_q.rd;
            commit_o.data         <= wb_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o.valid && ex_i.is_load |-> !dmem_req_o.write);

endmodule

`default_nettype wire

// ==== verilog/ex.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire backend_pkg::disp_ex_t disp_i,
    output backend_pkg::fwd_t          ex_fwd_o,
    output logic                       ex_is_load_o,
    output logic                       branch_taken_o,
    output backend_pkg::word_t         branch_target_o,
    output backend_pkg::ex_mem_t       ex_o
);
    import backend_pkg::*;

    word_t alu;
    logic  eq;

    always_comb begin
        case (disp_i.alu_op)
            ALU_SUB:  alu = disp_i.op_a - disp_i.op_b;
            ALU_AND:  alu = disp_i.op_a & disp_i.op_b;
            ALU_OR:   alu = disp_i.op_a | disp_i.op_b;
            ALU_XOR:  alu = disp_i.op_a ^ disp_i.op_b;
            ALU_SLT:  alu = {31'b0, $signed(disp_i.op_a) < $signed(disp_i.op_b)};
            ALU_SLTU: alu = {31'b0, disp_i.op_a < disp_i.op_b};
            default:  alu = disp_i.op_a + disp_i.op_b;
        endcase
    end

    assign eq = (disp_i.op_a == disp_i.op_b);
    assign branch_taken_o  = disp_i.valid && ((disp_i.is_beq && eq) || (disp_i.is_bne && !eq));
    assign branch_target_o = disp_i.pc + disp_i.imm;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o <= '0;
        end else begin
            ex_o.valid        <= disp_i.valid;
            ex_o.pc           <= disp_i.pc;
            ex_o.rd           <= disp_i.rd;
            ex_o.reg_write_en <= disp_i.reg_write_en;
            ex_o.is_load      <= disp_i.is_load;
            ex_o.is_store     <= disp_i.is_store;
            ex_o.result       <= alu;
            ex_o.store_data   <= disp_i.store_data;
        end
    end

    // load data is not here yet
    assign ex_fwd_o.write_en = ex_o.valid && ex_o.reg_write_en && !ex_o.is_load;
    assign ex_fwd_o.addr     = ex_o.rd;
    assign ex_fwd_o.data     = ex_o.result;
    assign ex_is_load_o      = ex_o.valid && ex_o.reg_write_en && ex_o.is_load;

endmodule

`default_nettype wire

// ==== verilog/dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire backend_pkg::id_disp_t   id_i,
    input  wire backend_pkg::pipe_ctrl_t pipe_ctrl_i,
    input  wire backend_pkg::fwd_t       ex_fwd_i,
    input  wire backend_pkg::fwd_t       mem_fwd_i,
    input  wire logic                    ex_is_load_i,
    output backend_pkg::reg_addr_t       raddr_a_o,
    output backend_pkg::reg_addr_t       raddr_b_o,
    input  wire backend_pkg::word_t      rdata_a_i,
    input  wire backend_pkg::word_t      rdata_b_i,
    output logic                         stall_req_o,
    output backend_pkg::disp_ex_t        disp_o
);
    import backend_pkg::*;

    word_t    val_a;
    word_t    val_b;
    logic     uses_b;
    disp_ex_t nxt;

    function automatic word_t pick(reg_addr_t a, word_t rf, fwd_t exf, fwd_t memf);
        if (a != '0 && exf.write_en && exf.addr == a)
            return exf.data;
        if (a != '0 && memf.write_en && memf.addr == a)
            return memf.data;
        return rf;
    endfunction

    // producer still computing, or a load not yet back
    function automatic logic pending(reg_addr_t a, disp_ex_t ahead, fwd_t exf, logic ld);
        if (a == '0)
            return 1'b0;
        return (ahead.valid && ahead.reg_write_en && ahead.rd == a) || (ld && exf.addr == a);
    endfunction

    assign raddr_a_o = id_i.rj;
    assign raddr_b_o = id_i.rk;
    assign uses_b    = !id_i.use_imm || id_i.is_store;

    assign val_a = pick(id_i.rj, rdata_a_i, ex_fwd_i, mem_fwd_i);
    assign val_b = pick(id_i.rk, rdata_b_i, ex_fwd_i, mem_fwd_i);

    assign stall_req_o = id_i.valid &&
        (pending(id_i.rj, disp_o, ex_fwd_i, ex_is_load_i) ||
         (uses_b && pending(id_i.rk, disp_o, ex_fwd_i, ex_is_load_i)));

    always_comb begin
        nxt.valid        = id_i.valid;
        nxt.pc           = id_i.pc;
        nxt.rd           = id_i.rd;
        nxt.alu_op       = id_i.alu_op;
        nxt.is_load      = id_i.is_load;
        nxt.is_store     = id_i.is_store;
        nxt.is_beq       = id_i.is_beq;
        nxt.is_bne       = id_i.is_bne;
        nxt.imm          = id_i.imm;
        nxt.reg_write_en = id_i.reg_write_en;
        nxt.op_a         = val_a;
        nxt.op_b         = id_i.use_imm ? id_i.imm : val_b;
        nxt.store_data   = val_b;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            disp_o <= '0;
        else if (pipe_ctrl_i.disp_flush || pipe_ctrl_i.disp_stall)
            disp_o.valid <= 1'b0;
        else
            disp_o <= nxt;
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire backend_pkg::reg_addr_t raddr_a_i,
    input  wire backend_pkg::reg_addr_t raddr_b_i,
    output backend_pkg::word_t      rdata_a_o,
    output backend_pkg::word_t      rdata_b_o,
    input  wire backend_pkg::fwd_t  wr_i
);
    import backend_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_i.write_en && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // write-first bypass
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (wr_i.write_en && wr_i.addr == raddr_a_i) ? wr_i.data : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (wr_i.write_en && wr_i.addr == raddr_b_i) ? wr_i.data : regs[raddr_b_i];

    assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_i.write_en |-> wr_i.addr != '0);

endmodule

`default_nettype wire

// ==== verilog/id.sv ====
`timescale 1ns/10ps
`default_nettype none

module id (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire backend_pkg::fe_inst_t   fe_i,
    input  wire backend_pkg::pipe_ctrl_t pipe_ctrl_i,
    output backend_pkg::id_disp_t        id_o
);
    import backend_pkg::*;

    inst_u    inst;
    id_disp_t dec;

    assign inst = fe_i.inst;

    always_comb begin
        dec              = '0;
        dec.valid        = fe_i.valid;
        dec.pc           = fe_i.pc;
        dec.rj           = inst.r.rj;
        dec.rk           = inst.r.rk;
        dec.rd           = inst.r.rd;
        dec.alu_op       = ALU_ADD;
        dec.imm          = {{20{inst.i.imm[11]}}, inst.i.imm};
        dec.reg_write_en = 1'b1;
        case (inst.r.op)
            OP_ADD_W: dec.alu_op = ALU_ADD;
            OP_SUB_W: dec.alu_op = ALU_SUB;
            OP_SLT:   dec.alu_op = ALU_SLT;
            OP_SLTU:  dec.alu_op = ALU_SLTU;
            OP_AND:   dec.alu_op = ALU_AND;
            OP_OR:    dec.alu_op = ALU_OR;
            OP_XOR:   dec.alu_op = ALU_XOR;
            default: begin
                dec.use_imm = 1'b1;
                case (inst.i.op)
                    OP_ADDI_W: ;
                    OP_LD_W:   dec.is_load = 1'b1;
                    OP_ST_W: begin
                        // store data comes from rd
                        dec.is_store     = 1'b1;
                        dec.rk           = inst.i.rd;
                        dec.reg_write_en = 1'b0;
                    end
                    default: begin
                        dec.use_imm      = 1'b0;
                        dec.rk           = inst.i.rd;
                        dec.reg_write_en = 1'b0;
                        dec.imm = {{14{inst.i.op[3]}}, inst.i.op[3:0], inst.i.imm, 2'b00};
                        dec.is_beq = (inst.i.op[9:4] == OP_BEQ);
                        dec.is_bne = (inst.i.op[9:4] == OP_BNE);
                        // unknown opcode turns into a bubble
                        if (!dec.is_beq && !dec.is_bne)
                            dec.valid = 1'b0;
                    end
                endcase
            end
        endcase
        if (dec.rd == '0)
            dec.reg_write_en = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            id_o <= '0;
        else if (pipe_ctrl_i.id_flush)
            id_o.valid <= 1'b0;
        else if (!pipe_ctrl_i.id_stall)
            id_o <= dec;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pipe_ctrl_i.id_stall && pipe_ctrl_i.id_flush));

endmodule

`default_nettype wire

// ==== verilog/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // three-register view
    typedef struct packed {
        logic [16:0] op;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_r_t;

    // immediate view
    // branches take offs16 from op[3:0] and imm
    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] imm;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    localparam logic [5:0]  OP_BEQ    = 6'h16;
    localparam logic [5:0]  OP_BNE    = 6'h17;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_u inst;
    } fe_inst_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_beq;
        logic      is_bne;
        word_t     imm;
        logic      reg_write_en;
    } id_disp_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      is_load;
        logic      is_store;
        logic      is_beq;
        logic      is_bne;
        word_t     imm;
        logic      reg_write_en;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
    } disp_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_write_en;
        logic      is_load;
        logic      is_store;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      write_en;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_write_en;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic id_stall;
        logic id_flush;
        logic disp_stall;
        logic disp_flush;
    } pipe_ctrl_t;

endpackage

`default_nettype wire
